/* pll_lock_ctrl.f */
pll_cfg_pkg.sv
pll_state_pkg.sv
pll_cmd_decode.sv
pll_freq_stepper.sv
pll_phase_tracker.sv
pll_lock_status.sv
pll_lock_ctrl.sv
tb_clk_gen.sv
pll_lock_ctrl_assert.sv
pll_lock_ctrl_tb.sv

/* pll_lock_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_lock_ctrl_tb;

  import pll_cfg_pkg::*;

  localparam int unsigned START_DLY      = 6;
  localparam int unsigned LOCK_THRESHOLD = 12;
  localparam int unsigned SEED           = 32'h9e78_3fe8;
  // planned test lengths in cycles
  localparam int CMD_LEN  = 6;
  localparam int NUM_CMDS = 16;
  localparam int PUMP_LEN = 5 * START_DLY + 24 + 4 + 5;
  localparam int LOCK_LEN = 5 * (LOCK_THRESHOLD + 4);
  localparam int HOLD_LEN = 40 + 3 * 9 + 20;
  localparam int TIMEOUT_CYCLES =
    2 * (8 + CMD_LEN * NUM_CMDS + PUMP_LEN + LOCK_LEN + HOLD_LEN);

  logic       ref_clk;
  logic       feedback;
  logic       cfg_req;
  cfg_op_t    cfg_op;
  cfg_data_t  cfg_data;
  logic       pll_bypass;
  logic       phase_match;
  logic       cfg_ack;
  logic       freq_locked;
  logic       pll_lock;
  step_cnt_t  step_count;
  err_cnt_t   sync_errors;

  // reference model state
  // hs 0 idle, 1 ack high, 2 wait for req low
  // stepper 0 stopped, 1 startup, 2 pump, 3 freq locked
  int          m_hs, m_state, m_dly;
  logic        m_set, m_start, m_stop, m_clr, m_fl, m_slip, m_lock, n_lock, n_slip;
  step_cnt_t   m_load, m_step, m_store, load;
  match_cnt_t  m_match, n_match;
  err_cnt_t    m_err, n_err;
  int unsigned match_pct;
  int          cycles = 0;

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(8)) u_clk_gen (.ref_clk(ref_clk), .feedback(feedback));

  pll_lock_ctrl #(.START_DLY(START_DLY), .LOCK_THRESHOLD(LOCK_THRESHOLD)) UUT (.*);

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_step(input string name, input step_cnt_t got, input step_cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_err(input string name, input err_cnt_t got, input err_cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // four-phase host sequence, samples ack on the falling edge
  task automatic send_cmd(input cfg_op_t op, input cfg_data_t data);
    @(posedge ref_clk);
    cfg_req  <= 1'b1;
    cfg_op   <= op;
    cfg_data <= data;
    @(negedge ref_clk);
    while (!cfg_ack) @(negedge ref_clk);
    @(posedge ref_clk);
    cfg_req <= 1'b0;
    @(negedge ref_clk);
    while (cfg_ack) @(negedge ref_clk);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge ref_clk);
  endtask

  // comparator sample with adjustable match probability
  always @(posedge ref_clk) begin
    phase_match <= ($urandom_range(99) < match_pct);
  end

  // cycle model, all next values from pre-edge state and inputs
  always @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      m_hs    = 0;
      m_state = 0;
      m_dly   = 0;
      {m_set, m_start, m_stop, m_clr, m_fl, m_slip, m_lock} = '0;
      m_step  = DEFAULT_STEP_COUNT;
      m_store = DEFAULT_STEP_COUNT;
      m_match = '0;
      m_err   = '0;
    end else begin
      // status, errors only count while locked
      n_lock = m_fl && (m_match >= LOCK_THRESHOLD) && (m_err == 0);
      n_err  = m_err;
      if (m_clr) n_err = '0;
      else if (m_slip && m_lock && (m_err != 4'd15)) n_err = m_err + 4'd1;
      // tracker
      n_match = '0;
      n_slip  = 1'b0;
      if (m_fl && !pll_bypass) begin
        if (phase_match) n_match = (m_match == 8'd255) ? m_match : m_match + 8'd1;
        else n_slip = 1'b1;
      end
      // stepper, stop beats everything
      if (m_stop) begin
        m_state = 0;
        m_step  = m_store;
        m_fl    = 1'b0;
      end else begin
        if (m_set) m_store = m_load;
        case (m_state)
          0: begin
            if (m_set) m_step = m_load;
            else if (m_start) begin
              m_state = 1;
              m_dly   = START_DLY;
            end
          end
          1: begin
            m_dly--;
            if (m_dly == 0) m_state = 2;
          end
          2: begin
            if (m_step != 0) m_step--;
            if (m_step == 0) begin
              m_state = 3;
              m_fl    = 1'b1;
            end
          end
          default: ;
        endcase
      end
      // handshake and action pulses
      {m_set, m_start, m_stop, m_clr} = '0;
      case (m_hs)
        0: if (cfg_req) begin
          m_hs    = 1;
          m_set   = (cfg_op == OP_SET_STEPS);
          m_start = (cfg_op == OP_START);
          m_stop  = (cfg_op == OP_STOP);
          m_clr   = (cfg_op == OP_CLEAR_ERR);
          if (m_set) m_load = cfg_data;
        end
        1: m_hs = cfg_req ? 2 : 0;
        default: if (!cfg_req) m_hs = 0;
      endcase
      m_lock  = n_lock;
      m_err   = n_err;
      m_match = n_match;
      m_slip  = n_slip;
    end
  end

  // every output against the model, away from the active edge
  always @(negedge ref_clk) begin
    if (UUT.u_assert.fail_count != 0) begin
      $display("Assertion failure at %0t: a bound check on the DUT failed", $time);
      stop_on_error();
    end
    if (!feedback) begin
      check_bit("cfg_ack", cfg_ack, m_hs != 0);
      check_bit("freq_locked", freq_locked, m_fl);
      check_bit("pll_lock", pll_lock, m_lock);
      check_step("step_count", step_count, m_step);
      check_err("sync_errors", sync_errors, m_err);
    end
  end

  always @(posedge ref_clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    void'($urandom(SEED));
    cfg_req     = 1'b0;
    cfg_op      = OP_SET_STEPS;
    cfg_data    = '0;
    pll_bypass  = 1'b0;
    phase_match = 1'b0;
    match_pct   = 0;
    @(negedge ref_clk);
    while (feedback) @(negedge ref_clk);
    // reset value, then a load while stopped
    check_step("step_count", step_count, DEFAULT_STEP_COUNT);
    load = step_cnt_t'(8 + $urandom_range(16));
    send_cmd(OP_SET_STEPS, cfg_data_t'(load));
    check_step("step_count", step_count, load);
    // countdown to frequency lock, then a load of zero
    match_pct = 100;
    send_cmd(OP_START, '0);
    while (!freq_locked) @(negedge ref_clk);
    check_step("step_count", step_count, '0);
    send_cmd(OP_STOP, '0);
    send_cmd(OP_SET_STEPS, '0);
    send_cmd(OP_START, '0);
    while (!freq_locked) @(negedge ref_clk);
    // random mismatches before lock restart the run
    send_cmd(OP_STOP, '0);
    match_pct = 40;
    send_cmd(OP_SET_STEPS, 8'd4);
    send_cmd(OP_START, '0);
    while (!freq_locked) @(negedge ref_clk);
    wait_cycles(40);
    check_err("sync_errors", sync_errors, '0);
    match_pct = 100;
    while (!pll_lock) @(negedge ref_clk);
    // one error per lock, cleared each round
    for (int r = 0; r < 3; r++) begin
      match_pct = 0;
      wait_cycles(4 + $urandom_range(4));
      check_bit("pll_lock", pll_lock, 1'b0);
      check_err("sync_errors", sync_errors, 4'd1);
      send_cmd(OP_CLEAR_ERR, '0);
      match_pct = 100;
      while (!pll_lock) @(negedge ref_clk);
    end
    // bypass freezes tracking without errors
    match_pct = 50;
    @(posedge ref_clk);
    pll_bypass <= 1'b1;
    wait_cycles(20);
    check_bit("pll_lock", pll_lock, 1'b0);
    check_err("sync_errors", sync_errors, '0);
    match_pct = 100;
    @(posedge ref_clk);
    pll_bypass <= 1'b0;
    while (!pll_lock) @(negedge ref_clk);
    // stop in the middle of pumping
    send_cmd(OP_STOP, '0);
    send_cmd(OP_SET_STEPS, 8'd30);
    send_cmd(OP_START, '0);
    wait_cycles(START_DLY + 5);
    send_cmd(OP_STOP, '0);
    check_step("step_count", step_count, 8'd30);
    check_bit("freq_locked", freq_locked, 1'b0);
    // let the last edges pass through the bound checks
    wait_cycles(2);
    if (UUT.u_assert.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Assertion failure: a bound check on the DUT failed");
      $display("Verification failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

/* pll_lock_ctrl_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_lock_ctrl_assert (
  input wire                          ref_clk,
  input wire                          feedback,
  input wire                          cfg_req,
  input wire                          cfg_ack,
  input wire                          freq_locked,
  input wire                          pll_lock,
  input wire                          clr_err,
  input wire pll_cfg_pkg::err_cnt_t   sync_errors
);

  // failed assertions so far, watched by the testbench
  int unsigned fail_count = 0;

  // ack only ever answers a request
  ack_needs_req: assert property (@(posedge ref_clk) disable iff (feedback)
    $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      fail_count++;
      $error("cfg_ack rose while cfg_req was low");
    end

  // lock is registered from freq_locked, so it trails it by one edge
  lock_needs_freq: assert property (@(posedge ref_clk) disable iff (feedback)
    pll_lock |-> $past(freq_locked))
    else begin
      fail_count++;
      $error("pll_lock high without freq_locked");
    end

  // error count only goes down through a clear pulse
  err_only_cleared: assert property (@(posedge ref_clk) disable iff (feedback)
    (sync_errors < $past(sync_errors)) |-> $past(clr_err))
    else begin
      fail_count++;
      $error("sync_errors decreased without a clear command");
    end

endmodule

bind pll_lock_ctrl pll_lock_ctrl_assert u_assert (.*);

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 8
) (
  output logic ref_clk,
  output logic feedback
);

  initial begin
    ref_clk = 1'b0;
    forever #(PERIOD / 2) ref_clk = ~ref_clk;
  end

  // reset held for a fixed number of rising edges, released on an edge
  initial begin
    feedback = 1'b1;
    repeat (RST_CYCLES) @(posedge ref_clk);
    feedback <= 1'b0;
  end

endmodule

`default_nettype wire

/* pll_lock_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_lock_ctrl #(
  parameter int unsigned START_DLY      = 6,
  parameter int unsigned LOCK_THRESHOLD = 12
) (
  input  wire                           ref_clk,
  // asynchronous reset, active high
  input  wire                           feedback,
  input  wire                           cfg_req,
  input  wire pll_cfg_pkg::cfg_op_t     cfg_op,
  input  wire pll_cfg_pkg::cfg_data_t   cfg_data,
  input  wire                           pll_bypass,
  input  wire                           phase_match,
  output logic                          cfg_ack,
  output logic                          freq_locked,
  output logic                          pll_lock,
  output pll_cfg_pkg::step_cnt_t        step_count,
  output pll_cfg_pkg::err_cnt_t         sync_errors
);

  import pll_cfg_pkg::*;

  // decode to execute
  logic       set_steps;
  logic       start;
  logic       stop;
  logic       clr_err;
  step_cnt_t  step_load;

  // tracker to status
  match_cnt_t match_cnt;
  logic       slip;

  // command handshake
  cfg_decode u_decode (
    .ref_clk   (ref_clk),
    .feedback  (feedback),
    .cfg_req   (cfg_req),
    .cfg_op    (cfg_op),
    .cfg_data  (cfg_data),
    .cfg_ack   (cfg_ack),
    .set_steps (set_steps),
    .start     (start),
    .stop      (stop),
    .clr_err   (clr_err),
    .step_load (step_load)
  );

  pll_freq_stepper #(
    .START_DLY (START_DLY)
  ) u_stepper (
    .ref_clk     (ref_clk),
    .feedback    (feedback),
    .set_steps   (set_steps),
    .start       (start),
    .stop        (stop),
    .step_load   (step_load),
    .step_count  (step_count),
    .freq_locked (freq_locked)
  );

  pll_phase_tracker u_tracker (
    .ref_clk     (ref_clk),
    .feedback    (feedback),
    .freq_locked (freq_locked),
    .pll_bypass  (pll_bypass),
    .phase_match (phase_match),
    .match_cnt   (match_cnt),
    .slip        (slip)
  );

  // lock and error status
  pll_lock_status #(
    .LOCK_THRESHOLD (LOCK_THRESHOLD)
  ) u_status (
    .ref_clk     (ref_clk),
    .feedback    (feedback),
    .freq_locked (freq_locked),
    .match_cnt   (match_cnt),
    .slip        (slip),
    .clr_err     (clr_err),
    .pll_lock    (pll_lock),
    .sync_errors (sync_errors)
  );

endmodule

`default_nettype wire

/* pll_lock_status.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_lock_status #(
  // consecutive matches needed for lock
  parameter int unsigned LOCK_THRESHOLD = 12
) (
  input  wire                           ref_clk,
  input  wire                           feedback,
  input  wire                           freq_locked,
  input  wire pll_cfg_pkg::match_cnt_t  match_cnt,
  input  wire                           slip,
  input  wire                           clr_err,
  output logic                          pll_lock,
  output pll_cfg_pkg::err_cnt_t         sync_errors
);

  import pll_cfg_pkg::*;

  localparam match_cnt_t LOCK_MIN = match_cnt_t'(LOCK_THRESHOLD);

  always_ff @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      pll_lock <= 1'b0;
    end else begin
      // any counted error keeps lock off until cleared
      pll_lock <= freq_locked && (match_cnt >= LOCK_MIN) && (sync_errors == '0);
    end
  end

  // slip arrives one cycle after the mismatch, pll_lock still reflects
  // the run that was broken
  always_ff @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      sync_errors <= '0;
    end else if (clr_err) begin
      sync_errors <= '0;
    end else if (slip && pll_lock && (sync_errors != ERR_CNT_MAX)) begin
      sync_errors <= sync_errors + err_cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

/* pll_phase_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_phase_tracker (
  input  wire                       ref_clk,
  input  wire                       feedback,
  input  wire                       freq_locked,
  input  wire                       pll_bypass,
  // comparator sample, high when feedback edge lines up with ref edge
  input  wire                       phase_match,
  output pll_cfg_pkg::match_cnt_t   match_cnt,
  output logic                      slip
);

  import pll_cfg_pkg::*;

  logic track_en;

  // tracking only once frequency is locked
  // bypass freezes it
  assign track_en = freq_locked && !pll_bypass;

  always_ff @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      match_cnt <= '0;
      slip      <= 1'b0;
    end else if (track_en) begin
      if (phase_match) begin
        // consecutive matches, stick at max
        if (match_cnt != MATCH_CNT_MAX) begin
          match_cnt <= match_cnt + match_cnt_t'(1);
        end
        slip <= 1'b0;
      end else begin
        // any mismatch restarts the run
        match_cnt <= '0;
        slip      <= 1'b1;
      end
    end else begin
      match_cnt <= '0;
      slip      <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* pll_freq_stepper.sv */
`default_nettype none
`timescale 1ns/1ps

module pll_freq_stepper #(
  // start-up delay in cycles, 1 to 256
  parameter int unsigned START_DLY = 6
) (
  input  wire                           ref_clk,
  input  wire                           feedback,
  input  wire                           set_steps,
  input  wire                           start,
  input  wire                           stop,
  input  wire pll_cfg_pkg::step_cnt_t   step_load,
  output pll_cfg_pkg::step_cnt_t        step_count,
  output logic                          freq_locked
);

  import pll_cfg_pkg::*;
  import pll_state_pkg::*;

  // delay counter runs down from here to zero
  localparam dly_cnt_t DLY_LAST = dly_cnt_t'(START_DLY - 1);

  step_state_e step_state;
  // last loaded step count, restored on stop
  step_cnt_t   step_store;
  dly_cnt_t    dly_cnt;

  always_ff @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      step_state  <= STOPPED;
      step_count  <= DEFAULT_STEP_COUNT;
      step_store  <= DEFAULT_STEP_COUNT;
      dly_cnt     <= '0;
      freq_locked <= 1'b0;
    end else if (stop) begin
      // stop wins from any state, like the old loop reset
      step_state  <= STOPPED;
      step_count  <= step_store;
      dly_cnt     <= '0;
      freq_locked <= 1'b0;
    end else begin
      // new load is always stored, but only applied when stopped
      if (set_steps) begin
        step_store <= step_load;
      end
      case (step_state)
        STOPPED: begin
          if (set_steps) begin
            step_count <= step_load;
          end else if (start) begin
            step_state <= STARTUP;
            dly_cnt    <= DLY_LAST;
          end
        end
        STARTUP: begin
          // step_count holds while the loop settles
          if (dly_cnt == '0) begin
            step_state <= PUMP;
          end else begin
            dly_cnt <= dly_cnt - dly_cnt_t'(1);
          end
        end
        PUMP: begin
          if (step_count != '0) begin
            step_count <= step_count - step_cnt_t'(1);
          end
          // lock flag rises on the edge that makes the count zero
          // a load of zero locks on the first pump edge
          if (step_count <= step_cnt_t'(1)) begin
            step_state  <= FREQ_LOCKED;
            freq_locked <= 1'b1;
          end
        end
        // holds until stop; start is ignored here
        FREQ_LOCKED: step_state <= FREQ_LOCKED;
        default: step_state <= STOPPED;
      endcase
    end
  end

endmodule

`default_nettype wire

/* pll_cmd_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module cfg_decode (
  input  wire                           ref_clk,
  input  wire                           feedback,
  input  wire                           cfg_req,
  input  wire pll_cfg_pkg::cfg_op_t     cfg_op,
  input  wire pll_cfg_pkg::cfg_data_t   cfg_data,
  output logic                          cfg_ack,
  output logic                          set_steps,
  output logic                          start,
  output logic                          stop,
  output logic                          clr_err,
  output pll_cfg_pkg::step_cnt_t        step_load
);

  import pll_cfg_pkg::*;
  import pll_state_pkg::*;

  hs_state_e hs_state;
  logic      accept;

  // a new request is only taken with ack low
  assign accept = (hs_state == IDLE) && cfg_req;

  // ack is high from the accepting edge until req is seen low
  assign cfg_ack = (hs_state != IDLE);

  always_ff @(posedge ref_clk or posedge feedback) begin
    if (feedback) begin
      hs_state  <= IDLE;
      set_steps <= 1'b0;
      start     <= 1'b0;
      stop      <= 1'b0;
      clr_err   <= 1'b0;
    end else begin
      // pulses last one cycle only
      set_steps <= 1'b0;
      start     <= 1'b0;
      stop      <= 1'b0;
      clr_err   <= 1'b0;
      case (hs_state)
        IDLE: begin
          if (cfg_req) begin
            hs_state  <= ACK_HIGH;
            // exactly one action per request
            set_steps <= (cfg_op == OP_SET_STEPS);
            start     <= (cfg_op == OP_START);
            stop      <= (cfg_op == OP_STOP);
            clr_err   <= (cfg_op == OP_CLEAR_ERR);
          end
        end
        // host may already have dropped req
        ACK_HIGH:     hs_state <= cfg_req ? WAIT_REQ_LOW : IDLE;
        WAIT_REQ_LOW: if (!cfg_req) hs_state <= IDLE;
        default:      hs_state <= IDLE;
      endcase
    end
  end

  // step payload, valid together with the set_steps pulse
  always_ff @(posedge ref_clk) begin
    if (accept && (cfg_op == OP_SET_STEPS)) begin
      step_load <= cfg_data;
    end
  end

endmodule

`default_nettype wire

/* pll_state_pkg.sv */
`default_nettype none

package pll_state_pkg;

  // four-phase handshake on the command port
  // ack is high in every state except IDLE
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    ACK_HIGH     = 2'd1,
    WAIT_REQ_LOW = 2'd2
  } hs_state_e;

  // frequency stepper
  // STARTUP waits out the start-up delay, PUMP counts steps down
  typedef enum logic [1:0] {
    STOPPED     = 2'd0,
    STARTUP     = 2'd1,
    PUMP        = 2'd2,
    FREQ_LOCKED = 2'd3
  } step_state_e;

endpackage

`default_nettype wire

/* pll_cfg_pkg.sv */
`default_nettype none

package pll_cfg_pkg;

  // field widths
  localparam int CFG_OP_W    = 2;
  localparam int CFG_DATA_W  = 8;
  localparam int STEP_CNT_W  = 8;
  localparam int MATCH_CNT_W = 8;
  localparam int ERR_CNT_W   = 4;
  localparam int DLY_CNT_W   = 8;

  // host command port
  typedef logic [CFG_OP_W-1:0]    cfg_op_t;
  typedef logic [CFG_DATA_W-1:0]  cfg_data_t;

  // frequency stepper and tracking counters
  typedef logic [STEP_CNT_W-1:0]  step_cnt_t;
  typedef logic [MATCH_CNT_W-1:0] match_cnt_t;
  typedef logic [ERR_CNT_W-1:0]   err_cnt_t;
  typedef logic [DLY_CNT_W-1:0]   dly_cnt_t;

  // command codes carried on cfg_op
  // load the step count from cfg_data
  localparam cfg_op_t OP_SET_STEPS = 2'd0;
  localparam cfg_op_t OP_START     = 2'd1;
  // stop acts like the old asynchronous loop reset
  localparam cfg_op_t OP_STOP      = 2'd2;
  localparam cfg_op_t OP_CLEAR_ERR = 2'd3;

  // step count loaded at reset
  localparam step_cnt_t DEFAULT_STEP_COUNT = 8'd20;

  // saturation points
  localparam match_cnt_t MATCH_CNT_MAX = '1;
  localparam err_cnt_t   ERR_CNT_MAX   = '1;

endpackage

`default_nettype wire
